/* compile.f */
logic/host_pkg.sv
logic/mem_pkg.sv
logic/word_fifo.sv
logic/block_ram.sv
logic/dma_engine.sv
logic/dma_top.sv
sim/tb_dma_top.sv

/* run.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tb_dma_top -o tb_dma_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_dma_top > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Regression failed" "$log"; then
	exit 1
fi

exit 0

/* sim/tb_dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_top;
	import host_pkg::*;
	import mem_pkg::*;

	localparam int loop_blocks    = 8;
	localparam int backlog_blocks = mem_blocks + fifo_depth / block_words;
	localparam int stall_blocks   = 20;
	localparam int reset_blocks   = 3;
	localparam int stall_cycles   = 500;
	localparam int quiet_cycles   = 200;    // Longer than one block transfer
	localparam int watchdog_cycles =
		200 * (loop_blocks + backlog_blocks + stall_blocks + reset_blocks) + 2000;

	logic        okClk;
	logic        arst_n;
	logic [31:0] ctrl_word;
	logic        pipe_in_write;
	logic [31:0] pipe_in_data;
	logic        pipe_out_read;
	logic        pipe_in_ready;
	logic        pipe_out_ready;
	logic [31:0] pipe_out_data;

	logic [31:0] rng_state = 32'h894b;
	logic [31:0] model_q[$];                // Accepted words in arrival order
	int          errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	dma_top dma_top_inst (
		.okClk(okClk), .arst_n(arst_n), .ctrl_word(ctrl_word),
		.pipe_in_write(pipe_in_write), .pipe_in_data(pipe_in_data),
		.pipe_out_read(pipe_out_read), .pipe_in_ready(pipe_in_ready),
		.pipe_out_ready(pipe_out_ready), .pipe_out_data(pipe_out_data)
	);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge okClk);
		$display("Watchdog expired before the tests finished");
		$display("Regression failed");
		$finish;
	end

	//------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [31:0] ctrl_value(input logic reads, input logic writes,
		input logic rst);
		logic [31:0] w;
		w = '0;
		w[ctrl_reads_bit]  = reads;
		w[ctrl_writes_bit] = writes;
		w[ctrl_reset_bit]  = rst;
		return w;
	endfunction

	task automatic expect_word(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		assert (actual === expected) else begin
			$display("ERR %0t: %s expected %h, got %h", $time, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("Test %s: PASS", name);
			tests_passed++;
		end else begin
			$display("Test %s: FAIL with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	// One block on consecutive cycles once the caller has seen pipe_in_ready
	task automatic write_block();
		logic [31:0] word;
		for (int i = 0; i < block_words; i++) begin
			word = next_random();
			pipe_in_write = 1'b1;
			pipe_in_data  = word;
			model_q.push_back(word);
			@(negedge okClk);
		end
		pipe_in_write = 1'b0;
	endtask

	task automatic read_block();
		logic [31:0] expected;
		for (int i = 0; i < block_words; i++) begin
			assert (model_q.size() > 0) else begin
				$display("DUT offered more words than were sent, at %0t", $time);
				errors++;
			end
			if (model_q.size() > 0) begin
				expected = model_q.pop_front();
				expect_word(expected, pipe_out_data, "pipe_out_data");
			end
			pipe_out_read = 1'b1;
			@(negedge okClk);
		end
		pipe_out_read = 1'b0;
		@(negedge okClk);                    // Let the throttle flag catch up
	endtask

	task automatic drain_model();
		while (model_q.size() > 0) begin
			if (pipe_out_ready) read_block();
			else @(negedge okClk);
		end
	endtask

	// Sends n blocks when allowed and reads whenever a block is waiting
	task automatic exchange_blocks(input int n_blocks);
		int sent;
		sent = 0;
		while (sent < n_blocks || model_q.size() > 0) begin
			if (pipe_out_ready) begin
				read_block();
			end else if (sent < n_blocks && pipe_in_ready) begin
				write_block();
				sent++;
			end else begin
				@(negedge okClk);
			end
		end
	endtask

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial begin
		int mark;
		int accepted;
		int low_run;
		int idle;
		int sent;
		logic seen_high;

		arst_n        = 1'b0;
		ctrl_word     = '0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		repeat (4) @(negedge okClk);
		arst_n = 1'b1;

		mark = errors;
		expect_word(32'(0), 32'(pipe_in_ready), "pipe_in_ready at release");
		expect_word(32'(0), 32'(pipe_out_ready), "pipe_out_ready at release");
		@(negedge okClk);
		expect_word(32'(1), 32'(pipe_in_ready), "pipe_in_ready after reset");
		expect_word(32'(0), 32'(pipe_out_ready), "pipe_out_ready after reset");
		report_test("reset flags", mark);

		mark = errors;
		ctrl_word = ctrl_value(1'b1, 1'b1, 1'b0);
		exchange_blocks(loop_blocks);
		report_test("loopback", mark);

		// Writes only so memory and input FIFO fill up
		mark = errors;
		ctrl_word = ctrl_value(1'b0, 1'b1, 1'b0);
		accepted = 0;
		low_run = 0;
		while (low_run < quiet_cycles) begin
			if (pipe_in_ready) begin
				write_block();
				accepted += block_words;
				low_run = 0;
			end else begin
				@(negedge okClk);
				low_run++;
			end
		end
		assert (accepted > mem_blocks * block_words + in_ready_limit
			&& accepted <= mem_blocks * block_words + fifo_depth) else begin
			$display("ERR %0t: accepted words expected %0d to %0d, got %0d", $time,
				mem_blocks * block_words + in_ready_limit + 1,
				mem_blocks * block_words + fifo_depth, accepted);
			errors++;
		end
		ctrl_word = ctrl_value(1'b1, 1'b1, 1'b0);
		drain_model();
		report_test("input back-pressure", mark);

		mark = errors;
		idle = 0;
		sent = 0;
		while (idle < stall_cycles) begin
			if (sent < stall_blocks && pipe_in_ready) begin
				write_block();
				sent++;
				idle += block_words;
			end else begin
				@(negedge okClk);
				idle++;
			end
		end
		exchange_blocks(stall_blocks - sent);
		report_test("output back-pressure", mark);

		// Two blocks parked in memory before a soft reset
		mark = errors;
		ctrl_word = ctrl_value(1'b0, 1'b1, 1'b0);
		write_block();
		write_block();
		repeat (2 * 3 * block_words + 20) @(negedge okClk);
		ctrl_word = ctrl_value(1'b1, 1'b1, 1'b1);
		@(negedge okClk);
		ctrl_word = ctrl_value(1'b1, 1'b1, 1'b0);
		model_q.delete();
		seen_high = 1'b0;
		for (int i = 0; i < quiet_cycles && !seen_high; i++) begin
			@(negedge okClk);
			seen_high = pipe_out_ready;
			expect_word(32'(0), 32'(pipe_out_ready), "pipe_out_ready after soft reset");
		end
		exchange_blocks(1);
		report_test("soft reset", mark);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_top (
	input  logic                        okClk,
	input  logic                        arst_n,
	input  logic [31:0]                 ctrl_word,
	input  logic                        pipe_in_write,
	input  logic [host_pkg::word_w-1:0] pipe_in_data,
	input  logic                        pipe_out_read,
	output logic                        pipe_in_ready,
	output logic                        pipe_out_ready,
	output logic [host_pkg::word_w-1:0] pipe_out_data
);
	import host_pkg::*;
	import mem_pkg::*;

	logic                  reads_en;
	logic                  writes_en;
	logic                  soft_reset;
	logic [word_w-1:0]     in_data;
	logic [count_w-1:0]    in_count;
	logic                  in_pop;
	logic [word_w-1:0]     out_data;
	logic [count_w-1:0]    out_count;
	logic                  out_push;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [mem_addr_w-1:0] wb_adr;
	logic [word_w-1:0]     wb_dat_w;
	logic [word_w-1:0]     wb_dat_r;
	logic                  wb_ack;

	assign reads_en   = ctrl_word[ctrl_reads_bit];
	assign writes_en  = ctrl_word[ctrl_writes_bit];
	assign soft_reset = ctrl_word[ctrl_reset_bit];

	//------------------------------------------------------------
	// Host -> in_fifo -> DMA -> memory -> DMA -> out_fifo -> host
	//------------------------------------------------------------
	word_fifo in_fifo (
		.okClk(okClk), .arst_n(arst_n), .clear(soft_reset),
		.push(pipe_in_write), .push_data(pipe_in_data),
		.pop(in_pop), .pop_data(in_data), .count(in_count),
		.full(), .empty()
	);

	dma_engine dma_engine_inst (
		.okClk(okClk), .arst_n(arst_n), .soft_reset(soft_reset),
		.reads_en(reads_en), .writes_en(writes_en),
		.in_data(in_data), .in_count(in_count), .out_count(out_count),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.in_pop(in_pop), .out_push(out_push), .out_data(out_data),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w)
	);

	block_ram block_ram_inst (
		.okClk(okClk), .arst_n(arst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	word_fifo out_fifo (
		.okClk(okClk), .arst_n(arst_n), .clear(soft_reset),
		.push(out_push), .push_data(out_data),
		.pop(pipe_out_read), .pop_data(pipe_out_data), .count(out_count),
		.full(), .empty()
	);

	// Block throttle, one cycle behind the fill counts
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else if (soft_reset) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready  <= int'(in_count) <= in_ready_limit;   // Room for a block
			pipe_out_ready <= int'(out_count) >= block_words;     // Whole block waiting
		end
	end

endmodule

`default_nettype wire

/* logic/dma_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
	input  logic                           okClk,
	input  logic                           arst_n,
	input  logic                           soft_reset,
	input  logic                           reads_en,
	input  logic                           writes_en,
	input  logic [host_pkg::word_w-1:0]    in_data,
	input  logic [host_pkg::count_w-1:0]   in_count,
	input  logic [host_pkg::count_w-1:0]   out_count,
	input  logic [host_pkg::word_w-1:0]    wb_dat_r,
	input  logic                           wb_ack,
	output logic                           in_pop,
	output logic                           out_push,
	output logic [host_pkg::word_w-1:0]    out_data,
	output logic                           wb_cyc,
	output logic                           wb_stb,
	output logic                           wb_we,
	output logic [mem_pkg::mem_addr_w-1:0] wb_adr,
	output logic [host_pkg::word_w-1:0]    wb_dat_w
);
	import host_pkg::*;
	import mem_pkg::*;

	enum logic [1:0] {st_idle, st_write, st_read} state;

	logic [$clog2(mem_blocks)-1:0]  wr_blk;     // Next block slot to fill
	logic [$clog2(mem_blocks)-1:0]  rd_blk;     // Oldest stored block
	logic [$clog2(mem_blocks):0]    stored;     // 0 to mem_blocks
	logic [$clog2(block_words)-1:0] word_cnt;
	logic                           start_write;
	logic                           start_read;
	logic                           last_word;

	//------------------------------------------------------------
	// Block start conditions
	//------------------------------------------------------------
	assign start_write = writes_en
		&& (int'(in_count) >= block_words)
		&& (int'(stored) < mem_blocks);

	// Output FIFO must take a whole block
	assign start_read = reads_en
		&& (stored != '0)
		&& (int'(out_count) <= fifo_depth - block_words);

	assign last_word = word_cnt == '1;

	//------------------------------------------------------------
	// Burst FSM
	//------------------------------------------------------------
	// Per word: stb alone, then ack, then one idle cycle
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			wb_cyc   <= 1'b0;
			wb_stb   <= 1'b0;
			wr_blk   <= '0;
			rd_blk   <= '0;
			stored   <= '0;
			word_cnt <= '0;
		end else if (soft_reset) begin
			state    <= st_idle;
			wb_cyc   <= 1'b0;
			wb_stb   <= 1'b0;
			wr_blk   <= '0;
			rd_blk   <= '0;
			stored   <= '0;
			word_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start_write) begin       // Writes win a tie
						state  <= st_write;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
					end else if (start_read) begin
						state  <= st_read;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
					end
				end
				default: begin
					if (wb_ack) begin
						wb_stb   <= 1'b0;
						word_cnt <= word_cnt + 1'b1;    // Wraps to 0 after last
						if (last_word) begin
							state  <= st_idle;
							wb_cyc <= 1'b0;
							if (state == st_write) begin
								wr_blk <= wr_blk + 1'b1;
								stored <= stored + 1'b1;
							end else begin
								rd_blk <= rd_blk + 1'b1;
								stored <= stored - 1'b1;
							end
						end
					end else if (!wb_stb) begin
						wb_stb <= 1'b1;        // Gap cycle over
					end
				end
			endcase
		end
	end

	//------------------------------------------------------------
	// Bus and FIFO side
	//------------------------------------------------------------
	assign wb_we  = state == st_write;
	assign wb_adr = (state == st_read) ? {rd_blk, word_cnt} : {wr_blk, word_cnt};

	// Head of input FIFO stays put until its ack
	assign wb_dat_w = in_data;
	assign in_pop   = wb_ack && (state == st_write);

	assign out_data = wb_dat_r;
	assign out_push = wb_ack && (state == st_read);

endmodule

`default_nettype wire

/* logic/block_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module block_ram (
	input  logic                          okClk,
	input  logic                          arst_n,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [mem_pkg::mem_addr_w-1:0] wb_adr,
	input  logic [31:0]                   wb_dat_w,   // Wishbone data bus
	output logic [31:0]                   wb_dat_r,
	output logic                          wb_ack
);
	import mem_pkg::*;

	logic [31:0] mem [mem_words];
	logic        req;

	// New request, not the cycle already being acked
	assign req = wb_cyc && wb_stb && !wb_ack;

	//------------------------------------------------------------
	// Single-cycle ack
	//------------------------------------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	//------------------------------------------------------------
	// Storage, write or read on the edge that raises ack
	//------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (req) begin
			if (wb_we) begin
				mem[wb_adr] <= wb_dat_w;
			end else begin
				wb_dat_r <= mem[wb_adr];   // Valid together with ack
			end
		end
	end

endmodule

`default_nettype wire

/* logic/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module word_fifo (
	input  logic                        okClk,
	input  logic                        arst_n,
	input  logic                        clear,
	input  logic                        push,
	input  logic [host_pkg::word_w-1:0] push_data,
	input  logic                        pop,
	output logic [host_pkg::word_w-1:0] pop_data,
	output logic [host_pkg::count_w-1:0] count,
	output logic                        full,
	output logic                        empty
);
	import host_pkg::*;

	logic [word_w-1:0]             mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	logic                          do_push;
	logic                          do_pop;

	assign do_push = push && !full;    // Drop writes when full
	assign do_pop  = pop && !empty;    // Drop reads when empty

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // Both or neither
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

	// Head word shows without a read strobe
	assign pop_data = mem[rd_ptr];
	assign full     = count == count_w'(fifo_depth);
	assign empty    = count == '0;

endmodule

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	//------------------------------------------------------------
	// Block memory geometry
	//------------------------------------------------------------

	// Word address on the Wishbone bus
	localparam int mem_addr_w = 8;

	localparam int mem_words = 256;

	// Capacity counted in host blocks of 16 words
	localparam int mem_blocks = 16;

endpackage

`default_nettype wire

/* logic/host_pkg.sv */
`default_nettype none

package host_pkg;

	//------------------------------------------------------------
	// Data words and block framing
	//------------------------------------------------------------
	localparam int word_w      = 32;
	localparam int block_words = 16;   // Host block, reduced for simulation

	//------------------------------------------------------------
	// Host FIFOs
	//------------------------------------------------------------
	localparam int fifo_depth      = 64;
	localparam int count_w         = 7;    // Holds 0 to fifo_depth
	localparam int buffer_headroom = 4;    // Slack for count update latency

	// Highest input fill that still leaves room for a whole block
	localparam int in_ready_limit = fifo_depth - buffer_headroom - block_words;

	//------------------------------------------------------------
	// Control word bit positions
	//------------------------------------------------------------
	localparam int ctrl_reads_bit  = 0;
	localparam int ctrl_writes_bit = 1;
	localparam int ctrl_reset_bit  = 2;   // Soft reset of FIFOs and DMA

endpackage

`default_nettype wire
